//--- Bender.yml
package:
  name: gfx_vga_dbuf

sources:
  - gfx_pkg.sv
  - video_timing.sv
  - buffer_swap_fsm.sv
  - fb_writer.sv
  - fb_bank_pair.sv
  - pixel_fetch.sv
  - gfx_vga_dbuf.sv
  - target: test
    files:
      - tb_gfx_vga_dbuf.sv

//--- buffer_swap_fsm.sv
module buffer_swap_fsm (
  input  logic clk,
  input  logic arst_n,
  input  logic mem_switch,
  input  logic frame_start,
  output logic front_sel,
  output logic accept_en
);

  logic                 mem_switch_q;
  logic                 switch_rise;
  gfx_pkg::swap_state_e state;
  gfx_pkg::swap_state_e state_next;

  assign switch_rise = mem_switch & ~mem_switch_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mem_switch_q <= 1'b0;
    end else begin
      mem_switch_q <= mem_switch;
    end
  end

  // further edges while a swap is pending are absorbed
  always_comb begin
    state_next = state;
    case (state)
      gfx_pkg::SWAP_IDLE: begin
        if (switch_rise) begin
          state_next = gfx_pkg::SWAP_PENDING;
        end
      end
      gfx_pkg::SWAP_PENDING: begin
        if (frame_start) begin
          state_next = gfx_pkg::SWAP_FLIP;
        end
      end
      default: begin
        state_next = gfx_pkg::SWAP_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= gfx_pkg::SWAP_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // the new front bank is live for the whole FLIP cycle, so the
  // read data of pixel 0 is already muxed from it
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      front_sel <= 1'b0;
    end else if (state == gfx_pkg::SWAP_PENDING && frame_start) begin
      front_sel <= ~front_sel;
    end
  end

  assign accept_en = (state == gfx_pkg::SWAP_IDLE);

  // a flip only ever follows a frame boundary seen while pending
  assert property (@(posedge clk) disable iff (!arst_n)
    $changed(front_sel) |-> (state == gfx_pkg::SWAP_FLIP) && $past(frame_start));

endmodule

//--- fb_bank_pair.sv
module fb_bank_pair (
  input  logic                             clk,
  input  logic                             wr_en,
  input  logic                             front_sel,
  input  logic [gfx_pkg::FB_ADDR_BITS-1:0] wr_addr,
  input  logic [gfx_pkg::FB_ADDR_BITS-1:0] rd_addr,
  input  gfx_pkg::pixel_t                  wr_data,
  output gfx_pkg::pixel_t                  rd_data
);

  gfx_pkg::pixel_t bank0 [gfx_pkg::FB_DEPTH];
  gfx_pkg::pixel_t bank1 [gfx_pkg::FB_DEPTH];

  gfx_pkg::pixel_t rd_q0;
  gfx_pkg::pixel_t rd_q1;

  // front_sel 0 shows bank0 and draws into bank1
  always_ff @(posedge clk) begin
    if (wr_en) begin
      if (front_sel) begin
        bank0[wr_addr] <= wr_data;
      end else begin
        bank1[wr_addr] <= wr_data;
      end
    end
  end

  // both banks are read every cycle
  always_ff @(posedge clk) begin
    rd_q0 <= bank0[rd_addr];
    rd_q1 <= bank1[rd_addr];
  end

  // bank choice after the read register, so a flip reaches the
  // first pixel already in flight
  assign rd_data = front_sel ? rd_q1 : rd_q0;

  assert property (@(posedge clk) wr_en |-> (wr_addr < gfx_pkg::FB_DEPTH));

endmodule

//--- fb_writer.sv
module fb_writer (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic                          gfx_valid,
  input  logic                          accept_en,
  input  logic [gfx_pkg::X_BITS-1:0]     gfx_x,
  input  logic [gfx_pkg::Y_BITS-1:0]     gfx_y,
  input  logic [gfx_pkg::PIXEL_BITS-1:0] gfx_color,
  input  logic [gfx_pkg::META_BITS-1:0]  gfx_meta,
  output logic                          gfx_ready,
  output logic                          wr_en,
  output logic [gfx_pkg::FB_ADDR_BITS-1:0] wr_addr,
  output gfx_pkg::pixel_t               wr_data
);

  logic accept;
  logic in_range;

  // client is only held off during a buffer swap
  assign gfx_ready = accept_en;
  assign accept    = gfx_valid & accept_en;

  // off-screen writes still complete the handshake
  assign in_range = (gfx_x < gfx_pkg::H_VISIBLE) && (gfx_y < gfx_pkg::V_VISIBLE);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_en <= 1'b0;
    end else begin
      wr_en <= accept & in_range;
    end
  end

  // row-major linear address, only meaningful with wr_en
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_addr <= '0;
      wr_data <= '0;
    end else if (accept) begin
      wr_addr <= gfx_pkg::fb_addr_t'(gfx_y * gfx_pkg::H_VISIBLE + gfx_x);
      wr_data <= gfx_pkg::pixel_t'({gfx_color, gfx_meta});
    end
  end

endmodule

//--- gfx_pkg.sv
package gfx_pkg;

  // horizontal timing in clocks
  localparam int H_VISIBLE = 16;
  localparam int H_FRONT   = 2;
  localparam int H_SYNC    = 3;
  localparam int H_BACK    = 3;
  localparam int H_WHOLE   = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;

  // vertical timing in lines
  localparam int V_VISIBLE = 12;
  localparam int V_FRONT   = 1;
  localparam int V_SYNC    = 2;
  localparam int V_BACK    = 2;
  localparam int V_WHOLE   = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;

  // coordinate widths, wide enough for the raster counters as well
  localparam int X_BITS = 5;
  localparam int Y_BITS = 5;

  // one bank holds the visible area only
  localparam int FB_DEPTH     = H_VISIBLE * V_VISIBLE;
  localparam int FB_ADDR_BITS = 8;

  localparam int COLOR_BITS = 4;
  localparam int PIXEL_BITS = 3 * COLOR_BITS;
  localparam int META_BITS  = 4;

  typedef logic [FB_ADDR_BITS-1:0] fb_addr_t;

  // color channels high, metadata in the low bits
  typedef struct packed {
    logic [COLOR_BITS-1:0] red;
    logic [COLOR_BITS-1:0] grn;
    logic [COLOR_BITS-1:0] blu;
    logic [META_BITS-1:0]  meta;
  } pixel_t;

  // buffer swap sequencing
  typedef enum logic [1:0] {
    SWAP_IDLE,
    SWAP_PENDING,
    SWAP_FLIP
  } swap_state_e;

endpackage

//--- gfx_vga_dbuf.sv
module gfx_vga_dbuf (
  input  logic                           clk,
  input  logic                           arst_n,
  input  logic                           mem_switch,
  input  logic                           gfx_valid,
  input  logic [gfx_pkg::X_BITS-1:0]      gfx_x,
  input  logic [gfx_pkg::Y_BITS-1:0]      gfx_y,
  input  logic [gfx_pkg::PIXEL_BITS-1:0]  gfx_color,
  input  logic [gfx_pkg::META_BITS-1:0]   gfx_meta,
  output logic                           gfx_ready,
  output logic                           gfx_vsync,
  output logic [gfx_pkg::COLOR_BITS-1:0]  vga_red,
  output logic [gfx_pkg::COLOR_BITS-1:0]  vga_grn,
  output logic [gfx_pkg::COLOR_BITS-1:0]  vga_blu,
  output logic [gfx_pkg::META_BITS-1:0]   vga_meta,
  output logic                           vga_hsync,
  output logic                           vga_vsync,
  output logic                           vga_de
);

  // raster position
  logic [gfx_pkg::X_BITS-1:0] h_count;
  logic [gfx_pkg::Y_BITS-1:0] v_count;
  logic                       visible;
  logic                       hsync_raw;
  logic                       vsync_raw;
  logic                       frame_start;

  // swap control
  logic front_sel;
  logic accept_en;

  // bank ports
  logic                             wr_en;
  logic [gfx_pkg::FB_ADDR_BITS-1:0] wr_addr;
  gfx_pkg::pixel_t                  wr_data;
  logic [gfx_pkg::FB_ADDR_BITS-1:0] rd_addr;
  gfx_pkg::pixel_t                  rd_data;

  video_timing video_timing_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .h_count    (h_count),
    .v_count    (v_count),
    .visible    (visible),
    .hsync_raw  (hsync_raw),
    .vsync_raw  (vsync_raw),
    .frame_start(frame_start)
  );

  buffer_swap_fsm buffer_swap_fsm_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .mem_switch (mem_switch),
    .frame_start(frame_start),
    .front_sel  (front_sel),
    .accept_en  (accept_en)
  );

  fb_writer fb_writer_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .gfx_valid(gfx_valid),
    .accept_en(accept_en),
    .gfx_x    (gfx_x),
    .gfx_y    (gfx_y),
    .gfx_color(gfx_color),
    .gfx_meta (gfx_meta),
    .gfx_ready(gfx_ready),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data)
  );

  fb_bank_pair fb_bank_pair_i (
    .clk      (clk),
    .wr_en    (wr_en),
    .front_sel(front_sel),
    .wr_addr  (wr_addr),
    .rd_addr  (rd_addr),
    .wr_data  (wr_data),
    .rd_data  (rd_data)
  );

  pixel_fetch pixel_fetch_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .visible  (visible),
    .hsync_raw(hsync_raw),
    .vsync_raw(vsync_raw),
    .h_count  (h_count),
    .v_count  (v_count),
    .rd_data  (rd_data),
    .rd_addr  (rd_addr),
    .vga_red  (vga_red),
    .vga_grn  (vga_grn),
    .vga_blu  (vga_blu),
    .vga_meta (vga_meta),
    .vga_hsync(vga_hsync),
    .vga_vsync(vga_vsync),
    .vga_de   (vga_de)
  );

  // drawing client can pace itself on the displayed vsync
  assign gfx_vsync = vga_vsync;

endmodule

//--- list.f
gfx_pkg.sv
video_timing.sv
buffer_swap_fsm.sv
fb_writer.sv
fb_bank_pair.sv
pixel_fetch.sv
gfx_vga_dbuf.sv
tb_gfx_vga_dbuf.sv

//--- pixel_fetch.sv
module pixel_fetch (
  input  logic                             clk,
  input  logic                             arst_n,
  input  logic                             visible,
  input  logic                             hsync_raw,
  input  logic                             vsync_raw,
  input  logic [gfx_pkg::X_BITS-1:0]        h_count,
  input  logic [gfx_pkg::Y_BITS-1:0]        v_count,
  input  gfx_pkg::pixel_t                  rd_data,
  output logic [gfx_pkg::FB_ADDR_BITS-1:0] rd_addr,
  output logic [gfx_pkg::COLOR_BITS-1:0]   vga_red,
  output logic [gfx_pkg::COLOR_BITS-1:0]   vga_grn,
  output logic [gfx_pkg::COLOR_BITS-1:0]   vga_blu,
  output logic [gfx_pkg::META_BITS-1:0]    vga_meta,
  output logic                             vga_hsync,
  output logic                             vga_vsync,
  output logic                             vga_de
);

  logic visible_q;
  logic hsync_q;
  logic vsync_q;

  // park the address in the blanking area
  assign rd_addr = visible ? gfx_pkg::fb_addr_t'(v_count * gfx_pkg::H_VISIBLE + h_count) : '0;

  // align raster controls with the bank read
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      visible_q <= 1'b0;
      hsync_q   <= 1'b1;
      vsync_q   <= 1'b1;
    end else begin
      visible_q <= visible;
      hsync_q   <= hsync_raw;
      vsync_q   <= vsync_raw;
    end
  end

  // output stage, color forced to black outside the visible area
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      vga_de    <= 1'b0;
      vga_hsync <= 1'b1;
      vga_vsync <= 1'b1;
      vga_red   <= '0;
      vga_grn   <= '0;
      vga_blu   <= '0;
      vga_meta  <= '0;
    end else begin
      vga_de    <= visible_q;
      vga_hsync <= hsync_q;
      vga_vsync <= vsync_q;
      vga_red   <= visible_q ? rd_data.red  : '0;
      vga_grn   <= visible_q ? rd_data.grn  : '0;
      vga_blu   <= visible_q ? rd_data.blu  : '0;
      vga_meta  <= visible_q ? rd_data.meta : '0;
    end
  end

endmodule

//--- tb_gfx_vga_dbuf.sv
module tb_gfx_vga_dbuf;

  localparam int FRAME_CYCLES = gfx_pkg::H_WHOLE * gfx_pkg::V_WHOLE;
  // the longest test sequence fits well inside this many frames
  localparam int RUN_FRAMES   = 12;
  localparam int TIMEOUT      = RUN_FRAMES * FRAME_CYCLES * 4;

  logic                           clk;
  logic                           arst_n;
  logic                           mem_switch;
  logic                           gfx_valid;
  logic [gfx_pkg::X_BITS-1:0]     gfx_x;
  logic [gfx_pkg::Y_BITS-1:0]     gfx_y;
  logic [gfx_pkg::PIXEL_BITS-1:0] gfx_color;
  logic [gfx_pkg::META_BITS-1:0]  gfx_meta;
  logic                           gfx_ready;
  logic                           gfx_vsync;
  logic [gfx_pkg::COLOR_BITS-1:0] vga_red;
  logic [gfx_pkg::COLOR_BITS-1:0] vga_grn;
  logic [gfx_pkg::COLOR_BITS-1:0] vga_blu;
  logic [gfx_pkg::META_BITS-1:0]  vga_meta;
  logic                           vga_hsync;
  logic                           vga_vsync;
  logic                           vga_de;

  // reference framebuffer, one entry per bank
  gfx_pkg::pixel_t model_bank [2][gfx_pkg::FB_DEPTH];
  bit              known      [2][gfx_pkg::FB_DEPTH];
  logic            front_m = 1'b0;
  bit              swap_seen = 1'b0;

  int pixel_errors = 0;
  int count_errors = 0;
  int swaps_requested = 0;
  int swaps_seen = 0;
  logic [15:0] lfsr_state;

  // raster monitor state
  logic ready_q = 1'b1;
  logic hs_q = 1'b1;
  logic vs_q = 1'b1;
  bit   line_seen = 1'b0;
  bit   frame_seen = 1'b0;
  int   hs_low = 0;
  int   vs_low = 0;
  int   line_len = 0;
  int   frame_len = 0;
  int   de_line = 0;
  int   active_lines = 0;
  int   pix_idx = 0;

  gfx_vga_dbuf gfx_vga_dbuf_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .mem_switch(mem_switch),
    .gfx_valid (gfx_valid),
    .gfx_x     (gfx_x),
    .gfx_y     (gfx_y),
    .gfx_color (gfx_color),
    .gfx_meta  (gfx_meta),
    .gfx_ready (gfx_ready),
    .gfx_vsync (gfx_vsync),
    .vga_red   (vga_red),
    .vga_grn   (vga_grn),
    .vga_blu   (vga_blu),
    .vga_meta  (vga_meta),
    .vga_hsync (vga_hsync),
    .vga_vsync (vga_vsync),
    .vga_de    (vga_de)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // 16-bit Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // pixel the display should show at a linear position of the front bank
  function automatic gfx_pkg::pixel_t expected_pixel(input int idx);
    return model_bank[front_m][idx];
  endfunction

  task automatic check_pixel(input gfx_pkg::pixel_t got, input gfx_pkg::pixel_t exp,
                             input int idx, input string what);
    if (got !== exp) begin
      pixel_errors++;
      $display("Mismatch at %0t: %s at pixel %0d, got %h expected %h",
               $time, what, idx, got, exp);
    end
  endtask

  task automatic check_count(input string what, input int got, input int exp);
    if (got != exp) begin
      count_errors++;
      $display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic take_random(input int n, output logic [15:0] val);
    int i;
    val = '0;
    for (i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      val = {val[14:0], lfsr_state[0]};
    end
  endtask

  // holds valid until the request is taken, stalls included
  task automatic draw(input int x, input int y, input logic [11:0] color,
                      input logic [3:0] meta);
    gfx_valid <= 1'b1;
    gfx_x     <= x;
    gfx_y     <= y;
    gfx_color <= color;
    gfx_meta  <= meta;
    @(posedge clk);
    while (!gfx_ready) @(posedge clk);
  endtask

  task automatic fill_frame();
    int x;
    int y;
    logic [15:0] color;
    logic [15:0] meta;
    for (y = 0; y < gfx_pkg::V_VISIBLE; y++) begin
      for (x = 0; x < gfx_pkg::H_VISIBLE; x++) begin
        take_random(12, color);
        take_random(4, meta);
        draw(x, y, color[11:0], meta[3:0]);
      end
    end
    gfx_valid <= 1'b0;
  endtask

  // edge raised during active video, extra edges land while pending
  task automatic request_swap(input int edges);
    int i;
    @(posedge clk);
    while (!vga_de) @(posedge clk);
    swaps_requested++;
    mem_switch <= 1'b1;
    @(posedge clk);
    @(posedge clk);
    check_count("gfx_ready after switch edge", int'(gfx_ready), 0);
    mem_switch <= 1'b0;
    for (i = 1; i < edges; i++) begin
      @(posedge clk);
      mem_switch <= 1'b1;
      @(posedge clk);
      mem_switch <= 1'b0;
    end
  endtask

  // ready comes back after the flip, then the first new frame ends
  task automatic wait_flip();
    @(posedge clk);
    while (!gfx_ready) @(posedge clk);
    @(negedge vga_vsync);
    @(posedge clk);
  endtask

  always @(posedge clk) begin : compare
    gfx_pkg::pixel_t got;
    int              addr;
    if (arst_n) begin
      got = gfx_pkg::pixel_t'({vga_red, vga_grn, vga_blu, vga_meta});
      // completed writes land in the back bank, off-screen ones are dropped
      if (gfx_valid && gfx_ready) begin
        if (gfx_x < gfx_pkg::H_VISIBLE && gfx_y < gfx_pkg::V_VISIBLE) begin
          addr = gfx_y * gfx_pkg::H_VISIBLE + gfx_x;
          model_bank[!front_m][addr] = gfx_pkg::pixel_t'({gfx_color, gfx_meta});
          known[!front_m][addr] = 1'b1;
        end
      end
      if (ready_q && !gfx_ready) begin
        swap_seen = 1'b1;
        swaps_seen++;
      end
      // ready returns with the first displayed pixel of the new frame
      if (!ready_q && gfx_ready) begin
        check_count("de at ready return", int'(vga_de), 1);
        check_count("pixel index at ready return", pix_idx, 0);
      end
      ready_q = gfx_ready;

      // horizontal timing
      line_len++;
      if (vga_de) de_line++;
      if (!vga_hsync) hs_low++;
      if (vga_hsync && !hs_q) begin
        check_count("hsync width", hs_low, gfx_pkg::H_SYNC);
        hs_low = 0;
      end
      if (!vga_hsync && hs_q) begin
        if (line_seen) check_count("line length", line_len, gfx_pkg::H_WHOLE);
        if (de_line != 0) begin
          check_count("de pixels per line", de_line, gfx_pkg::H_VISIBLE);
          active_lines++;
        end
        line_len  = 0;
        de_line   = 0;
        line_seen = 1'b1;
      end
      hs_q = vga_hsync;

      // vertical timing, the model flips on the sync after a seen swap
      check_count("gfx_vsync level", int'(gfx_vsync), int'(vga_vsync));
      frame_len++;
      if (!vga_vsync) vs_low++;
      if (vga_vsync && !vs_q) begin
        check_count("vsync width", vs_low, gfx_pkg::V_SYNC * gfx_pkg::H_WHOLE);
        vs_low = 0;
      end
      if (!vga_vsync && vs_q) begin
        if (frame_seen) check_count("frame length", frame_len, FRAME_CYCLES);
        check_count("active lines", active_lines, gfx_pkg::V_VISIBLE);
        if (swap_seen) begin
          front_m   = !front_m;
          swap_seen = 1'b0;
        end
        frame_len    = 0;
        active_lines = 0;
        pix_idx      = 0;
        frame_seen   = 1'b1;
      end
      vs_q = vga_vsync;

      if (vga_de) begin
        if (pix_idx < gfx_pkg::FB_DEPTH && known[front_m][pix_idx]) begin
          check_pixel(got, expected_pixel(pix_idx), pix_idx, "displayed pixel");
        end
        pix_idx++;
      end else begin
        check_pixel(got, '0, pix_idx, "blanked output");
      end
    end
  end

  initial begin
    #(TIMEOUT);
    $display("timeout: the run did not finish within %0d frame times", RUN_FRAMES);
    $display("tests failed");
    $finish;
  end

  initial begin
    int i;
    logic [15:0] color;
    logic [15:0] meta;
    arst_n     = 1'b0;
    mem_switch = 1'b0;
    gfx_valid  = 1'b0;
    gfx_x      = '0;
    gfx_y      = '0;
    gfx_color  = '0;
    gfx_meta   = '0;
    lfsr_state = 16'd32642;
    repeat (4) @(posedge clk);
    arst_n <= 1'b1;
    @(posedge clk);

    // write the back bank, then show it
    fill_frame();
    request_swap(1);
    wait_flip();

    // redraw the hidden bank while the first one is on screen
    fill_frame();
    request_swap(1);
    wait_flip();

    // swap in the middle of a fill with valid held high
    fork
      fill_frame();
      begin
        repeat (20) @(posedge clk);
        request_swap(1);
      end
    join
    wait_flip();

    // off-screen writes, then a swap with a second edge while pending
    for (i = 0; i < 8; i++) begin
      take_random(12, color);
      take_random(4, meta);
      draw(16 + 2 * i, i, color[11:0], meta[3:0]);
      draw(i, 12 + 2 * i, color[11:0], meta[3:0]);
    end
    gfx_valid <= 1'b0;
    request_swap(2);
    wait_flip();
    // a spurious second flip would show up in this frame
    @(negedge vga_vsync);
    @(posedge clk);

    check_count("swaps seen", swaps_seen, swaps_requested);
    $display("errors: %0d pixel, %0d count", pixel_errors, count_errors);
    if (pixel_errors + count_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- video_timing.sv
module video_timing (
  input  logic                      clk,
  input  logic                      arst_n,
  output logic [gfx_pkg::X_BITS-1:0] h_count,
  output logic [gfx_pkg::Y_BITS-1:0] v_count,
  output logic                      visible,
  output logic                      hsync_raw,
  output logic                      vsync_raw,
  output logic                      frame_start
);

  logic line_end;
  logic frame_end;
  logic in_hsync;
  logic in_vsync;

  assign line_end  = (h_count == gfx_pkg::H_WHOLE - 1);
  assign frame_end = (v_count == gfx_pkg::V_WHOLE - 1);

  // free running raster position
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      h_count <= '0;
      v_count <= '0;
    end else if (line_end) begin
      h_count <= '0;
      if (frame_end) begin
        v_count <= '0;
      end else begin
        v_count <= v_count + 1'b1;
      end
    end else begin
      h_count <= h_count + 1'b1;
    end
  end

  // sync pulses sit between the front and back porch
  assign in_hsync = (h_count >= gfx_pkg::H_VISIBLE + gfx_pkg::H_FRONT) &&
                    (h_count <  gfx_pkg::H_VISIBLE + gfx_pkg::H_FRONT + gfx_pkg::H_SYNC);
  assign in_vsync = (v_count >= gfx_pkg::V_VISIBLE + gfx_pkg::V_FRONT) &&
                    (v_count <  gfx_pkg::V_VISIBLE + gfx_pkg::V_FRONT + gfx_pkg::V_SYNC);

  // both syncs are active low
  assign hsync_raw = ~in_hsync;
  assign vsync_raw = ~in_vsync;

  assign visible = (h_count < gfx_pkg::H_VISIBLE) && (v_count < gfx_pkg::V_VISIBLE);

  // first clock of the first visible pixel
  assign frame_start = (h_count == '0) && (v_count == '0);

  // counters stay inside one line and one frame
  assert property (@(posedge clk) disable iff (!arst_n)
    (h_count < gfx_pkg::H_WHOLE) && (v_count < gfx_pkg::V_WHOLE));

endmodule
